// File: run.sh
#!/bin/sh
# build and run the rvCore testbench with Verilator; exit status reflects pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f rvCore.f \
    --top-module rvCoreTb \
    -Mdir obj_dir \
    -o rvCoreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/rvCoreSim 2>&1)
simStatus=$?
printf '%s\n' "$simOut"

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: rvCore.f
src/rvCorePkg.sv
src/aluDecoder.sv
src/alu.sv
src/regFile.sv
src/progCounter.sv
src/mainFsm.sv
src/rvCore.sv
tb/rvCore_properties.sv
tb/rvCoreTb.sv

// File: src/alu.sv
// 32-bit alu with add, sub, and, or, xor, signed slt and a zero flag
module alu import rvCorePkg::*;
(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  aluCtrlE         aluCtrl,
    output logic [XLEN-1:0] y,
    output logic            zero
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b); // signed compare for slt

    always_comb
    begin
        case (aluCtrl)
            ctrlAdd: y = a + b;
            ctrlSub: y = a - b;
            ctrlAnd: y = a & b;
            ctrlOr:  y = a | b;
            ctrlXor: y = a ^ b;
            ctrlSlt: y = {{(XLEN-1){1'b0}}, lessThan};
            default: y = a + b;
        endcase
    end

    // beq uses this after a subtract
    assign zero = (y == '0);

endmodule

// File: src/aluDecoder.sv
// combinational alu control decoder; maps aluOp and instruction fields onto an alu operation
module aluDecoder import rvCorePkg::*;
(
    input  aluOpE       aluOp,
    input  logic [2:0]  funct3,
    input  logic        funct7b5, // instr[30]
    input  logic        opb5,     // instr[5], set for r-type
    output aluCtrlE     aluCtrl
);

    logic rtypeSub;

    // subi does not exist, so immediate forms never subtract
    assign rtypeSub = funct7b5 & opb5;

    always_comb
    begin
        case (aluOp)
            aluAdd: aluCtrl = ctrlAdd;
            aluSub: aluCtrl = ctrlSub;
            aluFunct:
            begin
                case (funct3)
                    3'b000:  aluCtrl = rtypeSub ? ctrlSub : ctrlAdd; // add, addi, sub
                    3'b010:  aluCtrl = ctrlSlt; // slt, slti
                    3'b100:  aluCtrl = ctrlXor; // xor, xori
                    3'b110:  aluCtrl = ctrlOr;  // or, ori
                    3'b111:  aluCtrl = ctrlAnd; // and, andi
                    default: aluCtrl = ctrlAdd; // shifts etc. not supported
                endcase
            end
            default: aluCtrl = ctrlAdd;
        endcase
    end

endmodule

// File: src/mainFsm.sv
// multicycle control fsm; sequences each instruction and emits the datapath control word
module mainFsm import rvCorePkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  opcodeE opcode, // from the instruction register
    input  logic   zero,   // alu zero flag
    output ctrlT   ctrl,
    output logic   retire,
    output logic   trap
);

    fsmStateE state, stateNext;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            state <= sFetch; // first fetch right after reset
        else
            state <= stateNext;
    end

    // next-state logic
    always_comb
    begin
        stateNext = state;
        case (state)
            sFetch:    stateNext = sDecode;
            sDecode:
            begin
                case (opcode)
                    opLoad, opStore: stateNext = sMemAdr;
                    opRtype:         stateNext = sExecR;
                    opItype:         stateNext = sExecI;
                    opBranch:        stateNext = sBeq;
                    opJal:           stateNext = sJal;
                    default:         stateNext = sHalt; // illegal opcode, stop here
                endcase
            end
            sMemAdr:   stateNext = (opcode == opLoad) ? sMemRead : sMemWrite;
            sMemRead:  stateNext = sMemWb;
            sMemWb:    stateNext = sFetch;
            sMemWrite: stateNext = sFetch;
            sExecR:    stateNext = sAluWb;
            sExecI:    stateNext = sAluWb;
            sAluWb:    stateNext = sFetch;
            sBeq:      stateNext = sFetch;
            sJal:      stateNext = sAluWb; // link write follows
            sHalt:     stateNext = sHalt;  // only reset leaves
            default:   stateNext = sHalt;
        endcase
    end

    // control word per state
    always_comb
    begin
        ctrl = CTRL_IDLE;
        case (state)
            sFetch:
            begin
                ctrl.memRead   = 1'b1;
                ctrl.irWrite   = 1'b1;
                ctrl.srcA      = aSrcPc;
                ctrl.srcB      = bSrcFour;
                ctrl.resultSrc = resAluResult; // pc + 4 straight from the alu
                ctrl.pcWrite   = 1'b1;
            end
            sDecode:
            begin
                ctrl.srcA = aSrcOldPc; // branch or jal target into aluOut
                ctrl.srcB = bSrcImm;
            end
            sMemAdr:
            begin
                ctrl.srcA = aSrcRs1;
                ctrl.srcB = bSrcImm;
            end
            sMemRead:
            begin
                ctrl.adrSrc  = 1'b1;
                ctrl.memRead = 1'b1;
            end
            sMemWb:
            begin
                ctrl.resultSrc = resMemData;
                ctrl.regWrite  = 1'b1;
            end
            sMemWrite:
            begin
                ctrl.adrSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            sExecR:
            begin
                ctrl.srcA  = aSrcRs1;
                ctrl.srcB  = bSrcRs2;
                ctrl.aluOp = aluFunct;
            end
            sExecI:
            begin
                ctrl.srcA  = aSrcRs1;
                ctrl.srcB  = bSrcImm;
                ctrl.aluOp = aluFunct;
            end
            sAluWb:
            begin
                ctrl.resultSrc = resAluOut;
                ctrl.regWrite  = 1'b1;
            end
            sBeq:
            begin
                ctrl.srcA      = aSrcRs1;
                ctrl.srcB      = bSrcRs2;
                ctrl.aluOp     = aluSub;    // zero when rs1 == rs2
                ctrl.resultSrc = resAluOut; // target from decode
                ctrl.branch    = zero;      // raised only for a taken beq
            end
            sJal:
            begin
                ctrl.srcA      = aSrcOldPc; // link = oldPc + 4
                ctrl.srcB      = bSrcFour;
                ctrl.resultSrc = resAluOut; // jump target from decode
                ctrl.pcWrite   = 1'b1;
            end
            default: ctrl = CTRL_IDLE; // sHalt, nothing moves
        endcase
    end

    // last state of every instruction
    assign retire = (state == sMemWb) || (state == sMemWrite) ||
                    (state == sAluWb) || (state == sBeq);
    assign trap   = (state == sHalt);

endmodule

// File: src/progCounter.sv
// program counter with conditional load, plus the fetch-address copy used for branch targets
module progCounter import rvCorePkg::*;
(
    input  logic            clk,
    input  logic            rstN,
    input  logic [XLEN-1:0] pcNext,  // result bus
    input  logic            pcWrite,
    input  logic            branch,
    input  logic            zero,
    input  logic            irWrite,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] oldPc
);

    logic pcLoad;

    // taken beq or any unconditional update
    assign pcLoad = pcWrite | (branch & zero);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            pc <= RESET_PC;
        else if (pcLoad)
            pc <= pcNext;
    end

    // address of the instruction now in the ir
    always_ff @(posedge clk)
    begin
        if (irWrite)
            oldPc <= pc;
    end

endmodule

// File: src/regFile.sv
// 32x32 register file, two async read ports and one sync write port, x0 hardwired to zero
module regFile import rvCorePkg::*;
(
    input  logic                         clk,
    input  logic [$clog2(REG_COUNT)-1:0] a1,  // rs1
    input  logic [$clog2(REG_COUNT)-1:0] a2,  // rs2
    input  logic [$clog2(REG_COUNT)-1:0] a3,  // rd
    input  logic [XLEN-1:0]              wd3,
    input  logic                         we3,
    output logic [XLEN-1:0]              rd1,
    output logic [XLEN-1:0]              rd2
);

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (we3 && (a3 != '0)) // x0 never written
            regs[a3] <= wd3;
    end

    // x0 forced to zero on read
    assign rd1 = (a1 == '0) ? '0 : regs[a1];
    assign rd2 = (a2 == '0) ? '0 : regs[a2];

endmodule

// File: src/rvCore.sv
// multicycle rv32i subset core top; joins the fsm, pc, register file and alu to one memory port
module rvCore import rvCorePkg::*;
(
    input  logic            clk,
    input  logic            rstN,
    input  logic [XLEN-1:0] memRdata, // valid in the same cycle as mem.addr
    output memBusT          mem,
    output logic            retire,
    output logic            trap
);

    ctrlT            ctrl;
    opcodeE          opcode;
    aluCtrlE         aluCtrl;
    logic            zero;
    logic [XLEN-1:0] instrReg;  // instruction register
    logic [XLEN-1:0] dataReg;   // load data
    logic [XLEN-1:0] rs1Q;
    logic [XLEN-1:0] rs2Q;
    logic [XLEN-1:0] aluOutQ;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] srcAVal;
    logic [XLEN-1:0] srcBVal;
    logic [XLEN-1:0] result;    // shared result bus to pc and rd
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] oldPc;

    assign opcode = opcodeE'(instrReg[6:0]);

    always_ff @(posedge clk)
    begin
        if (ctrl.irWrite)
            instrReg <= memRdata;
        dataReg <= memRdata; // only meaningful after sMemRead
        rs1Q    <= rd1;
        rs2Q    <= rd2;
        aluOutQ <= aluResult;
    end

    // immediate by format
    always_comb
    begin
        case (opcode)
            opStore:  imm = {{20{instrReg[31]}}, instrReg[31:25], instrReg[11:7]};
            opBranch: imm = {{20{instrReg[31]}}, instrReg[7], instrReg[30:25],
                             instrReg[11:8], 1'b0};
            opJal:    imm = {{12{instrReg[31]}}, instrReg[19:12], instrReg[20],
                             instrReg[30:21], 1'b0};
            default:  imm = {{20{instrReg[31]}}, instrReg[31:20]}; // i-type and lw
        endcase
    end

    always_comb
    begin
        case (ctrl.srcA)
            aSrcPc:    srcAVal = pc;
            aSrcOldPc: srcAVal = oldPc;
            default:   srcAVal = rs1Q;
        endcase
        case (ctrl.srcB)
            bSrcImm:  srcBVal = imm;
            bSrcFour: srcBVal = XLEN'(4);
            default:  srcBVal = rs2Q;
        endcase
        case (ctrl.resultSrc)
            resMemData:   result = dataReg;
            resAluResult: result = aluResult;
            default:      result = aluOutQ;
        endcase
    end

    assign mem.addr  = ctrl.adrSrc ? aluOutQ : pc; // data access or fetch
    assign mem.wdata = rs2Q;                       // sw source
    assign mem.read  = ctrl.memRead;
    assign mem.write = ctrl.memWrite;

    mainFsm fsm0 (.clk, .rstN, .opcode, .zero, .ctrl, .retire, .trap);

    aluDecoder aluDec0
    (
        .aluOp(ctrl.aluOp), .funct3(instrReg[14:12]), .funct7b5(instrReg[30]),
        .opb5(instrReg[5]), .aluCtrl
    );

    alu alu0 (.a(srcAVal), .b(srcBVal), .aluCtrl, .y(aluResult), .zero);

    regFile rf0
    (
        .clk, .a1(instrReg[19:15]), .a2(instrReg[24:20]), .a3(instrReg[11:7]),
        .wd3(result), .we3(ctrl.regWrite), .rd1, .rd2
    );

    progCounter pc0
    (
        .clk, .rstN, .pcNext(result), .pcWrite(ctrl.pcWrite), .branch(ctrl.branch),
        .zero, .irWrite(ctrl.irWrite), .pc, .oldPc
    );

endmodule

// File: src/rvCorePkg.sv
// shared widths, opcode and state enums, and control structs; imported by every core module
package rvCorePkg;

    localparam int XLEN = 32;                  // data and address width
    localparam int REG_COUNT = 32;             // architectural registers x0..x31
    localparam logic [XLEN-1:0] RESET_PC = '0; // first fetch address

    // major opcodes of the supported subset
    typedef enum logic [6:0]
    {
        opLoad   = 7'b0000011, // lw
        opStore  = 7'b0100011, // sw
        opRtype  = 7'b0110011, // add sub and or xor slt
        opItype  = 7'b0010011, // addi andi ori xori slti
        opBranch = 7'b1100011, // beq
        opJal    = 7'b1101111  // jal
    } opcodeE;

    // operation class picked by the fsm
    typedef enum logic [1:0]
    {
        aluAdd   = 2'b00, // address, pc and jal arithmetic
        aluSub   = 2'b01, // beq compare
        aluFunct = 2'b10  // let funct3/funct7 decide
    } aluOpE;

    typedef enum logic [2:0]
    {
        ctrlAdd = 3'b000,
        ctrlSub = 3'b001,
        ctrlAnd = 3'b010,
        ctrlOr  = 3'b011,
        ctrlXor = 3'b100,
        ctrlSlt = 3'b101
    } aluCtrlE;

    typedef enum logic [3:0]
    {
        sFetch, sDecode, sMemAdr, sMemRead, sMemWb, sMemWrite,
        sExecR, sExecI, sAluWb, sBeq, sJal, sHalt
    } fsmStateE;

    typedef enum logic [1:0] {aSrcPc, aSrcOldPc, aSrcRs1} srcAE;        // alu operand a
    typedef enum logic [1:0] {bSrcRs2, bSrcImm, bSrcFour} srcBE;       // alu operand b
    typedef enum logic [1:0] {resAluOut, resMemData, resAluResult} resultSrcE;

    // datapath control word, one per fsm state
    typedef struct packed
    {
        logic      pcWrite;   // unconditional pc load
        logic      branch;    // pc load if zero
        logic      adrSrc;    // 0 pc, 1 aluOut onto mem.addr
        logic      memWrite;
        logic      memRead;
        logic      irWrite;   // latch instruction, capture oldPc
        logic      regWrite;
        srcAE      srcA;
        srcBE      srcB;
        resultSrcE resultSrc;
        aluOpE     aluOp;
    } ctrlT;

    // all strobes low
    localparam ctrlT CTRL_IDLE = '{pcWrite: 1'b0, branch: 1'b0, adrSrc: 1'b0, memWrite: 1'b0,
                                   memRead: 1'b0, irWrite: 1'b0, regWrite: 1'b0,
                                   srcA: aSrcPc, srcB: bSrcRs2, resultSrc: resAluOut,
                                   aluOp: aluAdd};

    // single shared instruction/data port
    typedef struct packed
    {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            read;
        logic            write;
    } memBusT;

endpackage

// File: tb/rvCoreTb.sv
// random-program testbench for rvCore; runs an ISA reference model beside the DUT and compares
module rvCoreTb import rvCorePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS = 1024;                 // 4 KB, program low, data from DATA_BASE
    localparam logic [31:0] DATA_BASE = 32'h400;
    localparam int BODY_LEN = 60;                    // random instructions

    logic            clk;
    logic            rstN;
    logic [XLEN-1:0] memRdata;
    memBusT          mem;
    logic            retire;
    logic            trap;
    logic [31:0]     memArr [MEM_WORDS];             // memory seen by the DUT
    logic [31:0]     modelMem [MEM_WORDS];           // model copy
    logic [31:0]     modelRegs [32];
    logic [31:0]     modelPc;
    int              modelCount;                     // instructions the model executed
    int              retireCount = 0;                // retire pulses seen on the port

    rvCore dut0 (.clk, .rstN, .memRdata, .mem, .retire, .trap);

    bind rvCore rvCoreProperties props0 (.clk, .rstN, .mem, .retire, .trap);

    assign memRdata = memArr[mem.addr[11:2]]; // combinational read
    always @(posedge clk)
    begin
        if (mem.write)
            memArr[mem.addr[11:2]] <= mem.wdata;
    end

    // every retire pulse out of reset
    always @(posedge clk)
    begin
        if (rstN && retire)
            retireCount <= retireCount + 1;
    end

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopOnError();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic abortWithReason(input string why);
        $display("%s", why);
        stopOnError();
    endtask

    task automatic compareValues(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED time %0t %s got 0x%h expected 0x%h", $time, name, got, exp);
            stopOnError();
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic buildProgram();
        int idx;
        int bodyEnd;
        int k;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3Table [5];
        f3Table = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
        for (int a = 0; a < MEM_WORDS; a++)
            memArr[a] = (32'(a) * 32'd4 * 32'h9E3779B1) ^ 32'hA5C30F69; // per byte address
        idx = 0;
        for (int r = 1; r < 31; r++)
        begin
            memArr[idx] = encI(12'($urandom), 5'd0, 3'b000, 5'(r), 7'b0010011); // addi xr
            idx++;
        end
        memArr[idx] = encI(12'(DATA_BASE), 5'd0, 3'b000, 5'd31, 7'b0010011); // x31 data base
        idx++;
        bodyEnd = idx + BODY_LEN;
        while (idx < bodyEnd)
        begin
            rd  = 5'($urandom_range(30, 0)); // x31 stays the base, x0 allowed
            rs1 = 5'($urandom_range(31, 0));
            rs2 = 5'($urandom_range(31, 0));
            k   = int'($urandom_range(4, 1));
            if (k > bodyEnd - idx)
                k = bodyEnd - idx;           // forward, at most onto the dump block
            case ($urandom_range(7, 0))
                0: memArr[idx] = encI(12'($urandom_range(127, 0) * 4), 5'd31, 3'b010, rd,
                                      7'b0000011);
                1: memArr[idx] = encS(12'($urandom_range(127, 0) * 4), rs2, 5'd31);
                2, 3:
                begin
                    if ($urandom_range(5, 0) == 0)
                        memArr[idx] = encR(7'h20, rs2, rs1, 3'b000, rd); // sub
                    else
                        memArr[idx] = encR(7'h00, rs2, rs1, f3Table[$urandom_range(4, 0)], rd);
                end
                4, 5: memArr[idx] = encI(12'($urandom), rs1, f3Table[$urandom_range(4, 0)],
                                         rd, 7'b0010011);
                6:
                begin
                    if ($urandom_range(1, 0) == 1)
                        rs2 = rs1; // force a taken branch
                    memArr[idx] = encB(13'(k * 4), rs2, rs1);
                end
                default: memArr[idx] = encJ(21'(k * 4), rd);
            endcase
            idx++;
        end
        for (int r = 1; r < 32; r++)
        begin
            memArr[idx] = encS(12'(r * 4), 5'(r), 5'd31); // dump register file
            idx++;
        end
        memArr[idx] = 32'h0000_0000; // opcode 0, illegal
        for (int a = 0; a < MEM_WORDS; a++)
            modelMem[a] = memArr[a];
    endtask

    // one instruction of the ISA model; cycles from the per-opcode table
    task automatic modelStep(output int cycles, output bit isStore, output logic [31:0] stAddr,
                             output logic [31:0] stData, output bit illegal);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] nextPc;
        bit          wr;
        ins    = modelMem[modelPc[11:2]];
        a      = modelRegs[ins[19:15]];
        b      = modelRegs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        cycles = 0;
        isStore = 1'b0;
        illegal = 1'b0;
        stAddr = '0;
        stData = '0;
        res    = '0;
        wr     = 1'b0;
        nextPc = modelPc + 32'd4;
        if (ins[6:0] == 7'b0010011)
            b = immI; // I-type uses the immediate, never subtracts
        case (ins[6:0])
            7'b0000011:
            begin
                cycles = 5;
                addr   = a + immI;
                res    = modelMem[addr[11:2]];
                wr     = 1'b1;
            end
            7'b0100011:
            begin
                cycles  = 4;
                isStore = 1'b1;
                stAddr  = a + immS;
                stData  = b;
                modelMem[stAddr[11:2]] = b;
            end
            7'b0110011, 7'b0010011:
            begin
                cycles = 4;
                wr     = 1'b1;
                case (ins[14:12])
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  res = a ^ b;
                    3'b110:  res = a | b;
                    3'b111:  res = a & b;
                    default: res = (ins[5] && ins[30]) ? a - b : a + b;
                endcase
            end
            7'b1100011:
            begin
                cycles = 3;
                if (a == b)
                    nextPc = modelPc + immB;
            end
            7'b1101111:
            begin
                cycles = 4;
                res    = modelPc + 32'd4; // link
                wr     = 1'b1;
                nextPc = modelPc + immJ;
            end
            default: illegal = 1'b1;
        endcase
        if (!illegal)
        begin
            if (wr && ins[11:7] != 5'd0)
                modelRegs[ins[11:7]] = res;
            modelPc = nextPc;
            modelCount++;
        end
    endtask

    // from the fetch cycle to the retire cycle, checking any store on the way
    task automatic followInstruction(input int cycles, input bit isStore,
                                     input logic [31:0] stAddr, input logic [31:0] stData);
        int c;
        bit done;
        bit sawStore;
        c = 1;
        done = 1'b0;
        sawStore = 1'b0;
        while (!done)
        begin
            if (mem.write)
            begin
                compareValues("mem.write", 32'(mem.write), 32'(isStore));
                compareValues("mem.addr", mem.addr, stAddr);
                compareValues("mem.wdata", mem.wdata, stData);
                sawStore = 1'b1;
            end
            if (retire)
            begin
                compareValues("retire cycle", 32'(c), 32'(cycles));
                done = 1'b1;
            end
            else if (c >= cycles + 4)
                abortWithReason("retire did not arrive within the expected cycles");
            @(negedge clk); // next cycle
            c++;
        end
        if (isStore && !sawStore)
            abortWithReason("store instruction retired without a memory write");
    endtask

    initial
    begin
        int cycles;
        bit isStore;
        bit illegal;
        logic [31:0] stAddr;
        logic [31:0] stData;
        int c;
        void'($urandom(31364));
        rstN = 1'b0;
        modelPc = RESET_PC;
        modelCount = 0;
        for (int r = 0; r < 32; r++)
            modelRegs[r] = '0;
        buildProgram();
        repeat (5) @(posedge clk);
        #1 rstN = 1'b1;
        c = 0;
        @(negedge clk);
        while (!mem.read)
        begin
            c++;
            if (c > 10)
                abortWithReason("no fetch after reset release");
            @(negedge clk);
        end
        compareValues("mem.addr", mem.addr, RESET_PC); // reset state
        compareValues("mem.write", 32'(mem.write), 32'd0);
        compareValues("retire", 32'(retire), 32'd0);
        compareValues("trap", 32'(trap), 32'd0);
        illegal = 1'b0;
        while (!illegal)
        begin
            compareValues("mem.read", 32'(mem.read), 32'd1); // fetch cycle
            compareValues("mem.addr", mem.addr, modelPc);
            modelStep(cycles, isStore, stAddr, stData, illegal);
            if (!illegal)
                followInstruction(cycles, isStore, stAddr, stData);
        end
        c = 1;
        while (!trap)
        begin
            if (retire || mem.write)
                abortWithReason("illegal opcode retired or wrote memory");
            c++;
            if (c > 10)
                abortWithReason("trap did not rise on the illegal opcode");
            @(negedge clk);
        end
        repeat (20)
        begin
            @(negedge clk);
            compareValues("trap", 32'(trap), 32'd1);
            compareValues("retire", 32'(retire), 32'd0);
            compareValues("mem.write", 32'(mem.write), 32'd0);
        end
        compareValues("retire count", 32'(retireCount), 32'(modelCount));
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // overall limit on top of the per-wait timeouts
    initial
    begin
        #200000;
        abortWithReason("simulation ran past its overall time limit");
    end

endmodule

// File: tb/rvCore_properties.sv
// concurrent checks on the memory strobes, retire and trap; bound into rvCore by the testbench
module rvCoreProperties import rvCorePkg::*;
(
    input logic   clk,
    input logic   rstN,
    input memBusT mem,
    input logic   retire,
    input logic   trap
);

    timeunit 1ns;
    timeprecision 100ps;

    // single port, so never both at once
    readWriteExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(mem.read && mem.write))
        else $error("mem.read and mem.write high in the same cycle");

    // one cycle per instruction end
    retireOneCycle: assert property (
        @(posedge clk) disable iff (!rstN) retire |=> !retire)
        else $error("retire held high for more than one cycle");

    // halt is sticky until reset
    trapSticky: assert property (
        @(posedge clk) disable iff (!rstN) trap |=> trap)
        else $error("trap dropped while out of reset");

    // word accesses only
    writeAligned: assert property (
        @(posedge clk) disable iff (!rstN) mem.write |-> (mem.addr[1:0] == 2'b00))
        else $error("store address not word aligned");

endmodule
